// File: nocPkg.sv
`default_nettype none

package nocPkg;

  localparam int NumPorts = 5;

  // Field widths of the flit
  localparam int DefaultLengthWidth = 12;
  localparam int DefaultPayloadWidth = 32;

  // Input port index, the order is also the rotation order
  typedef logic [2:0] portIdx_t;

  localparam portIdx_t PortL = 3'd0;
  localparam portIdx_t PortN = 3'd1;
  localparam portIdx_t PortE = 3'd2;
  localparam portIdx_t PortW = 3'd3;
  localparam portIdx_t PortS = 3'd4;

  // Flit kind
  typedef logic [2:0] flitId_t;

  localparam flitId_t FlitHead = 3'd1;  // Loads the hold budget
  localparam flitId_t FlitBody = 3'd2;
  localparam flitId_t FlitTail = 3'd3;

  // One-hot arbiter state
  // Bit 0 is idle and bits 1 to 5 name the owner from L to S
  typedef logic [NumPorts:0] grant_t;

  localparam grant_t GrantIdle = 6'b000001;
  localparam grant_t GrantL    = 6'b000010;
  localparam grant_t GrantN    = 6'b000100;
  localparam grant_t GrantE    = 6'b001000;
  localparam grant_t GrantW    = 6'b010000;
  localparam grant_t GrantS    = 6'b100000;

  typedef struct packed {
    flitId_t                        flitId;
    logic [DefaultLengthWidth-1:0]  length;   // Hold budget in cycles, header only
    logic [DefaultPayloadWidth-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

// File: flitTimer.sv
`default_nettype none

module flitTimer #(
  parameter int LengthWidth = nocPkg::DefaultLengthWidth
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire nocPkg::flit_t  flit,
  input  wire logic           runTimer,
  output logic                timesUp
);

  logic [LengthWidth-1:0] limit;  // Budget of the current packet
  logic [LengthWidth-1:0] count;  // Cycles held so far

  // Budget is taken from every header flit, granted or not
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flit.flitId == nocPkg::FlitHead)
    begin
      limit <= LengthWidth'(flit.length);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;  // Restart whenever the port is not holding
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

// File: rotatePicker.sv
`default_nettype none

module rotatePicker (
  input  wire logic [nocPkg::NumPorts-1:0] req,
  input  wire nocPkg::grant_t              state,
  output nocPkg::grant_t                   nextGrant
);

  localparam int NumPorts = nocPkg::NumPorts;

  nocPkg::portIdx_t      start;     // First port searched
  logic [2*NumPorts-1:0] reqTwice;
  logic [NumPorts-1:0]   rotReq;    // Requests seen from start
  nocPkg::portIdx_t      offset;
  logic                  found;
  logic [3:0]            sum;
  nocPkg::portIdx_t      winner;

  // Search begins one port after the owner
  // Idle and an owner at S both start from L
  always_comb
  begin
    start = nocPkg::PortL;
    for (int p = 0; p < NumPorts - 1; p++)
    begin
      if (state[p + 1])
      begin
        start = nocPkg::portIdx_t'(p + 1);
      end
    end
  end

  // The doubled vector lets a plain slice do the rotation
  assign reqTwice = {req, req};
  assign rotReq   = reqTwice[start +: NumPorts];

  // Lowest set bit of the rotated vector
  // The owner itself lands in the last position
  always_comb
  begin
    found  = 1'b0;
    offset = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (rotReq[i] && !found)
      begin
        found  = 1'b1;
        offset = nocPkg::portIdx_t'(i);
      end
    end
  end

  // Undo the rotation
  assign sum    = 4'(start) + 4'(offset);
  assign winner = (sum >= 4'(NumPorts)) ? nocPkg::portIdx_t'(sum - 4'(NumPorts))
                                        : nocPkg::portIdx_t'(sum);

  always_comb
  begin
    if (found)
    begin
      nextGrant = nocPkg::GrantL << winner;
    end
    else
    begin
      nextGrant = nocPkg::GrantIdle;  // Nobody asks
    end
  end

endmodule

`default_nettype wire

// File: switchArbiter.sv
`default_nettype none

module switchArbiter #(
  parameter int LengthWidth = nocPkg::DefaultLengthWidth
) (
  input  wire                             clk,
  input  wire                             rst,
  input  wire logic [nocPkg::NumPorts-1:0] req,
  input  wire nocPkg::flit_t              inFlit [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0]     grant
);

  localparam int NumPorts = nocPkg::NumPorts;

  nocPkg::grant_t      state;
  nocPkg::grant_t      nextState;
  nocPkg::grant_t      picked;     // Choice of the rotation search
  logic [NumPorts-1:0] owner;
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;
  logic                keep;

  // One budget timer per input port
  for (genvar p = 0; p < NumPorts; p++)
  begin : timerGen
    flitTimer #(
      .LengthWidth (LengthWidth)
    ) timer (
      .clk      (clk),
      .rst      (rst),
      .flit     (inFlit[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  rotatePicker picker (
    .req       (req),
    .state     (state),
    .nextGrant (picked)
  );

  assign owner = state[NumPorts:1];

  // Owner keeps counting while it asks and has budget left
  assign runTimer = owner & req & ~timesUp;
  assign keep     = |runTimer;

  always_comb
  begin
    if (!$onehot(state))
    begin
      nextState = nocPkg::GrantIdle;  // Recover from a broken encoding
    end
    else if (keep)
    begin
      nextState = state;
    end
    else
    begin
      nextState = picked;   // Release, expiry or leaving idle
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::GrantIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // Idle bit dropped, so an idle arbiter shows no grant
  assign grant = owner;

endmodule

`default_nettype wire

// File: flitSelect.sv
`default_nettype none

module flitSelect #(
  parameter type flitT = logic [31:0]
) (
  input  wire                             clk,
  input  wire                             rst,
  input  wire logic [nocPkg::NumPorts-1:0] grant,
  input  wire flitT                       inFlit [nocPkg::NumPorts],
  output flitT                            outFlit,
  output logic                            outValid
);

  localparam int NumPorts = nocPkg::NumPorts;
  localparam int FlitBits = $bits(flitT);

  logic [FlitBits-1:0] selBits;

  // AND-OR mux, grant is one-hot or zero
  always_comb
  begin
    selBits = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
      begin
        selBits = selBits | FlitBits'(inFlit[p]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= flitT'(selBits);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |grant;   // Marks the flit above as real
    end
  end

endmodule

`default_nettype wire

// File: outputPort.sv
`default_nettype none

module outputPort #(
  parameter int LengthWidth = nocPkg::DefaultLengthWidth
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire logic [nocPkg::NumPorts-1:0] req,
  input  wire nocPkg::flit_t               inFlit [nocPkg::NumPorts],
  output wire logic [nocPkg::NumPorts-1:0] grant,
  output nocPkg::flit_t                    outFlit,
  output logic                             outValid
);

  // Grant goes out and also steers the flit mux
  switchArbiter #(
    .LengthWidth (LengthWidth)
  ) arbiter (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .inFlit (inFlit),
    .grant  (grant)
  );

  flitSelect #(
    .flitT (nocPkg::flit_t)
  ) selector (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlit   (inFlit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

// File: outputPort_properties.sv
`default_nettype none

module outputPortProperties (
  input wire logic                        clk,
  input wire logic                        rst,
  input wire logic [nocPkg::NumPorts-1:0] req,
  input wire logic [nocPkg::NumPorts-1:0] grant,
  input wire logic                        outValid
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertFails = 0;

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    $error("grant has more than one bit set");
    assertFails++;
  end

  // First cycle out of reset
  resetClean: assert property (@(posedge clk) $fell(rst) |-> (grant == '0) && !outValid)
  else
  begin
    $error("grant or outValid not clear after reset");
    assertFails++;
  end

  grantFromReq: assert property (@(posedge clk) disable iff (rst)
                                 (grant != '0) |-> ((grant & $past(req)) != '0))
  else
  begin
    $error("grant given to a port that did not request");
    assertFails++;
  end

endmodule

bind outputPort outputPortProperties props (
  .clk      (clk),
  .rst      (rst),
  .req      (req),
  .grant    (grant),
  .outValid (outValid)
);

`default_nettype wire

// File: tb.sv
`default_nettype none

module tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumPorts      = nocPkg::NumPorts;
  localparam int LengthWidth   = nocPkg::DefaultLengthWidth;
  localparam int TimeoutCycles = 50;
  localparam int StressCycles  = 2000;

  typedef logic [LengthWidth-1:0] budgetArray_t [NumPorts];

  logic                clk;
  logic                rst;
  logic [NumPorts-1:0] req;
  nocPkg::flit_t       inFlit [NumPorts];
  logic [NumPorts-1:0] grant;
  nocPkg::flit_t       outFlit;
  logic                outValid;

  // Reference model registers
  nocPkg::grant_t      modelState;
  budgetArray_t        modelCount;
  budgetArray_t        modelLimit;
  logic [NumPorts-1:0] expGrant;
  nocPkg::flit_t       expFlit;
  logic                expValid;

  int seed;

  outputPort #(
    .LengthWidth (LengthWidth)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inFlit   (inFlit),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #20 clk = ~clk;

  function automatic nocPkg::flit_t makeFlit(nocPkg::flitId_t id, int length,
                                             logic [31:0] payload);
    nocPkg::flit_t f;
    f.flitId  = id;
    f.length  = LengthWidth'(length);
    f.payload = payload;
    return f;
  endfunction

  // Next owner by the allocation rules, searched port by port
  function automatic nocPkg::grant_t refNextState(nocPkg::grant_t state,
                                                  logic [NumPorts-1:0] reqs,
                                                  budgetArray_t count,
                                                  budgetArray_t limit);
    int owner;
    int port;
    owner = -1;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (state[p + 1])
        owner = p;
    end
    if (owner >= 0 && reqs[owner] && count[owner] != limit[owner])
      return state;  // Owner still asks and has budget
    for (int i = 1; i <= NumPorts; i++)
    begin
      port = (owner < 0) ? i - 1 : (owner + i) % NumPorts;
      if (reqs[port])
        return nocPkg::grant_t'(1 << (port + 1));
    end
    return nocPkg::GrantIdle;
  endfunction

  task automatic reportFailure(string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compareGrant(string name, logic [NumPorts-1:0] expected,
                              logic [NumPorts-1:0] actual);
    if (actual !== expected)
      reportFailure($sformatf("Error at time %0t: %s expected %b, got %b",
                              $time, name, expected, actual));
  endtask

  task automatic compareFlit(nocPkg::flit_t expected, logic expectedValid,
                             nocPkg::flit_t actual, logic actualValid);
    if (actualValid !== expectedValid)
      reportFailure($sformatf("Error at time %0t: outValid expected %b, got %b",
                              $time, expectedValid, actualValid));
    else if (expectedValid && actual !== expected)
      reportFailure($sformatf("Error at time %0t: outFlit expected %h, got %h",
                              $time, expected, actual));
  endtask

  // Advances the model by one rising edge
  task automatic updateModel();
    nocPkg::grant_t nextState;
    logic           run;
    if (rst)
    begin
      modelState = nocPkg::GrantIdle;
      expValid   = 1'b0;
      expFlit    = '0;
      for (int p = 0; p < NumPorts; p++)
      begin
        modelCount[p] = '0;
        modelLimit[p] = '0;
      end
    end
    else
    begin
      expValid = |modelState[NumPorts:1];
      expFlit  = '0;
      for (int p = 0; p < NumPorts; p++)
      begin
        if (modelState[p + 1])
          expFlit = inFlit[p];
      end
      nextState = refNextState(modelState, req, modelCount, modelLimit);
      for (int p = 0; p < NumPorts; p++)
      begin
        run = modelState[p + 1] && req[p] && (modelCount[p] != modelLimit[p]);
        modelCount[p] = run ? modelCount[p] + 1'b1 : '0;
        if (inFlit[p].flitId == nocPkg::FlitHead)
          modelLimit[p] = inFlit[p].length;
      end
      modelState = nextState;
    end
    expGrant = modelState[NumPorts:1];
  endtask

  always
  begin
    @(posedge clk);
    updateModel();
    #1;
    compareGrant("grant", expGrant, grant);
    compareFlit(expFlit, expValid, outFlit, outValid);
    if (u_dut.props.assertFails != 0)
      reportFailure("A concurrent assertion on the output port failed");
  end

  task automatic waitForGrant(logic [NumPorts-1:0] want, string what);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TimeoutCycles)
    begin
      @(posedge clk);
      #2;
      cycles++;
      if (grant === want)
        seen = 1'b1;
    end
    if (!seen)
      reportFailure($sformatf("The grant for %s never arrived within %0d cycles",
                              what, TimeoutCycles));
  endtask

  task automatic setBodyFlits();
    for (int p = 0; p < NumPorts; p++)
      inFlit[p] = makeFlit(nocPkg::FlitBody, 0, 32'hC0DE_0000 + p);
  endtask

  task automatic checkQuietAfterReset();
    repeat (3)
    begin
      @(posedge clk);
      #2;
      compareGrant("grant", '0, grant);
      compareFlit('0, 1'b0, outFlit, outValid);
    end
  endtask

  task automatic checkIdlePriority();
    @(negedge clk);
    req = NumPorts'((1 << nocPkg::PortN) | (1 << nocPkg::PortW) | (1 << nocPkg::PortS));
    waitForGrant(NumPorts'(1 << nocPkg::PortN), "port N from idle");
    @(posedge clk);
    #2;
    compareFlit(inFlit[nocPkg::PortN], 1'b1, outFlit, outValid);  // One cycle behind grant
    @(negedge clk);
    req = '0;
    waitForGrant('0, "idle after priority test");
  endtask

  task automatic checkBudget(int port, int nextPort, int k);
    int                  held;
    logic [NumPorts-1:0] ownerBit;
    logic [NumPorts-1:0] nextBit;
    ownerBit = NumPorts'(1 << port);
    nextBit  = NumPorts'(1 << nextPort);
    @(negedge clk);
    req          = '0;
    inFlit[port] = makeFlit(nocPkg::FlitHead, k, 32'hA000_0000 + k);
    @(negedge clk);
    inFlit[port] = makeFlit(nocPkg::FlitBody, 0, 32'hB000_0000 + k);
    req          = ownerBit | nextBit;
    waitForGrant(ownerBit, "budget owner");
    held = 1;
    while (grant === ownerBit && held <= k + 1)
    begin
      @(posedge clk);
      #2;
      if (grant === ownerBit)
        held++;
    end
    if (held != k + 1)
      reportFailure($sformatf("Error at time %0t: cycles held by port %0d expected %0d, got %0d",
                              $time, port, k + 1, held));
    compareGrant("grant", nextBit, grant);
    @(negedge clk);
    req = '0;
    waitForGrant('0, "idle after budget test");
  endtask

  task automatic checkRelease();
    @(negedge clk);
    inFlit[nocPkg::PortL] = makeFlit(nocPkg::FlitHead, 20, 32'h1111_0000);
    @(negedge clk);
    inFlit[nocPkg::PortL] = makeFlit(nocPkg::FlitBody, 0, 32'h1111_0001);
    req = NumPorts'((1 << nocPkg::PortL) | (1 << nocPkg::PortW));
    waitForGrant(NumPorts'(1 << nocPkg::PortL), "port L");
    @(negedge clk);
    req = NumPorts'(1 << nocPkg::PortW);  // L lets go early
    waitForGrant(NumPorts'(1 << nocPkg::PortW), "port W after release");
    @(negedge clk);
    req = '0;
    waitForGrant('0, "idle after release");
  endtask

  task automatic runStress();
    for (int c = 0; c < StressCycles; c++)
    begin
      @(negedge clk);
      req = NumPorts'($random(seed));
      for (int p = 0; p < NumPorts; p++)
        inFlit[p] = makeFlit(nocPkg::flitId_t'($random(seed) & 3), $random(seed) & 7,
                             $random(seed));
    end
  endtask

  initial
  begin
    seed   = 86;
    clk    = 1'b0;
    rst    = 1'b1;
    req    = '0;
    setBodyFlits();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    checkQuietAfterReset();
    checkIdlePriority();
    checkBudget(nocPkg::PortE, nocPkg::PortS, 0);
    checkBudget(nocPkg::PortE, nocPkg::PortS, 5);
    checkBudget(nocPkg::PortL, nocPkg::PortW, 3);
    checkRelease();
    runStress();

    @(negedge clk);
    req = '0;
    @(posedge clk);
    #2;
    if (u_dut.props.assertFails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
nocPkg.sv
flitTimer.sv
rotatePicker.sv
switchArbiter.sv
flitSelect.sv
outputPort.sv
outputPort_properties.sv
tb.sv

// File: Bender.yml
package:
  name: noc_output_port

dependencies: {}

sources:
  - nocPkg.sv
  - flitTimer.sv
  - rotatePicker.sv
  - switchArbiter.sv
  - flitSelect.sv
  - outputPort.sv
  - target: test
    files:
      - outputPort_properties.sv
      - tb.sv
